// ==== verilog.f ====
logic/multiboot_pkg.sv
logic/request_sync.sv
logic/boot_address_table.sv
logic/multiboot_sequencer.sv
logic/icap_port.sv
logic/switch_select.sv
logic/icap_multiboot_top.sv
verification/icap_model.sv
verification/tb_icap_multiboot.sv

// ==== Makefile ====
TOP = tb_icap_multiboot

.PHONY: all lint clean

# Build and run; the run passes only if the pass line is printed
all:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module icap_multiboot_top

clean:
	rm -rf obj_dir

// ==== verification/tb_icap_multiboot.sv ====
`timescale 1ns/1ps

module tb_icap_multiboot;

   localparam int STARTUP_CYCLES  = 15;
   localparam int NUM_TESTS       = 5;
   localparam int CYCLES_PER_TEST = 200;
   localparam int WAIT_LIMIT      = 100;       // Cycles allowed for an initialized change
   localparam int RECONFIG_WORDS  = 17;

   logic                       clk;
   logic                       arst_n;
   multiboot_pkg::design_num_t design_num;
   logic                       reconfigure;
   logic                       powerup;
   multiboot_pkg::switch_t     sw_in;
   logic                       busy;
   logic [15:0]                icap_dout;
   multiboot_pkg::icap_cmd_t   icap_out;
   multiboot_pkg::switch_t     sw_out;
   multiboot_pkg::switch_t     pwr_out;
   logic                       initialized;
   int                         busy_len;
   logic [15:0]                gen5_value;
   logic [15:0]                exp_q[$];

   icap_multiboot_top #(
      .STARTUP_CYCLES (STARTUP_CYCLES)
   ) dut_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .design_num  (design_num),
      .reconfigure (reconfigure),
      .powerup     (powerup),
      .sw_in       (sw_in),
      .busy        (busy),
      .icap_dout   (icap_dout),
      .icap_out    (icap_out),
      .sw_out      (sw_out),
      .pwr_out     (pwr_out),
      .initialized (initialized)
   );

   icap_model icap_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .icap_out   (icap_out),
      .busy_len   (busy_len),
      .gen5_value (gen5_value),
      .busy       (busy),
      .icap_dout  (icap_dout)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial
   begin
      repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
      fail_run("Watchdog expired before all tests finished");
   end

   // ------------------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------------------

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      if (actual !== expected)
         fail_run($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
   endtask

   // GENERAL_1 word in the upper half, GENERAL_2 word in the lower half
   function automatic logic [31:0] boot_words(input logic [4:0] dn);
      case (dn)
         5'b10000:               return 32'h0000_0300;
         5'd0, 5'd1, 5'd2, 5'd3: return 32'h4000_0305;
         5'd4:                   return 32'h8000_030A;
         5'd5, 5'd6, 5'd7:       return 32'hC000_030F;
         5'd8:                   return 32'h0000_0315;
         5'd9:                   return 32'h4000_031A;
         5'd10:                  return 32'h8000_031F;
         5'd11:                  return 32'hC000_0324;
         5'd12:                  return 32'h0000_032A;
         5'd13:                  return 32'h4000_032F;
         5'd14:                  return 32'h8000_0334;
         5'd15:                  return 32'hC000_0339;
         default:                return 32'h8000_0334; // Fallback image
      endcase
   endfunction

   task automatic apply_reset(input string name);
      @(negedge clk);
      arst_n = 1'b0;
      repeat (3) @(negedge clk);
      check_value({name, " reset strobes"}, 16'h0003, 16'({icap_out.ce_n, icap_out.wr_n}));
      check_value({name, " reset word"}, 16'hFFFF, icap_out.word.raw);
      arst_n = 1'b1;
   endtask

   task automatic wait_initialized(input string name, output int cycles);
      cycles = 0;
      while (!initialized && cycles < WAIT_LIMIT)
      begin
         @(negedge clk);
         cycles++;
      end
      if (!initialized)
         fail_run({name, ": initialized never went high"});
   endtask

   task automatic compare_log(input string name, input int start);
      check_value({name, " word count"}, 16'(exp_q.size()), 16'(icap_i.log_q.size() - start));
      foreach (exp_q[i])
         check_value($sformatf("%s word %0d", name, i), exp_q[i], icap_i.log_q[start + i]);
   endtask

   task automatic run_readback(input string name, input int len);
      int cycles;
      busy_len = len;
      apply_reset(name);
      check_value({name, " initialized after reset"}, 16'h0000, 16'(initialized));
      wait_initialized(name, cycles);
      repeat (2) @(negedge clk);                // Last word reaches the port a clock later
      exp_q = {16'hFFFF, 16'hAA99, 16'h5566, 16'h2000, 16'h2000, 16'h2AE1,
               16'h2000, 16'h2000, 16'h2000, 16'h2000,
               16'h30A1, 16'h000D, 16'h2000, 16'h2000};
      compare_log(name, 0);
      check_value({name, " sw_out"}, 16'(gen5_value[3:0]), 16'(sw_out));
      check_value({name, " pwr_out"}, 16'(gen5_value[7:4]), 16'(pwr_out));
   endtask

   task automatic run_reconfigure(input string name, input multiboot_pkg::design_num_t dn);
      logic [31:0] boot;
      logic [15:0] gen5;
      int          start;
      int          cycles;
      @(negedge clk);
      boot        = boot_words(dn);
      gen5        = {8'h00, powerup ? sw_in : gen5_value[7:4], powerup ? sw_in : dn[3:0]};
      start       = icap_i.log_q.size();
      design_num  = dn;
      reconfigure = 1'b1;
      cycles      = 0;
      while (initialized && cycles < WAIT_LIMIT)
      begin
         @(negedge clk);
         cycles++;
      end
      if (initialized)
         fail_run({name, ": reconfigure request was not taken"});
      reconfigure = 1'b0;
      wait_initialized(name, cycles);
      check_value({name, " cycles not initialized"}, 16'(RECONFIG_WORDS), 16'(cycles));
      repeat (2) @(negedge clk);
      exp_q = {16'hFFFF, 16'hFFFF, 16'hAA99, 16'h5566,
               16'h3261, boot[31:16], 16'h3281, boot[15:0], 16'h32E1, gen5,
               16'h30A1, 16'h000E,
               16'h2000, 16'h2000, 16'h2000, 16'h2000, 16'hFFFF};
      compare_log(name, start);
   endtask

   // ------------------------------------------------------------------------
   // Directed tests
   // ------------------------------------------------------------------------

   task automatic powerup_readback();
      run_readback("powerup readback", 3);
   endtask

   task automatic busy_stretch();
      run_readback("busy stretch 0", 0);
      run_readback("busy stretch 1", 1);
      run_readback("busy stretch random", $urandom_range(20, 2));
   endtask

   task automatic reconfigure_designs();
      run_reconfigure("design 0", 5'd0);
      run_reconfigure("design 4", 5'd4);
      run_reconfigure("design 5", 5'd5);
      run_reconfigure("design 9", 5'd9);
      run_reconfigure("design 15", 5'd15);
      run_reconfigure("design 10000", 5'b10000);
   endtask

   task automatic fallback_image();
      int base;
      run_reconfigure("fallback 10001", 5'b10001);
      base = icap_i.log_q.size() - RECONFIG_WORDS;
      check_value("fallback 10001 gen1", 16'h8000, icap_i.log_q[base + 5]);
      check_value("fallback 10001 gen2", 16'h0334, icap_i.log_q[base + 7]);
      run_reconfigure("fallback 11111", 5'b11111);
      base = icap_i.log_q.size() - RECONFIG_WORDS;
      check_value("fallback 11111 gen1", 16'h8000, icap_i.log_q[base + 5]);
      check_value("fallback 11111 gen2", 16'h0334, icap_i.log_q[base + 7]);
   endtask

   task automatic powerup_override();
      int base;
      @(negedge clk);
      powerup = 1'b1;
      sw_in   = 4'($urandom_range(15));
      @(negedge clk);
      check_value("powerup override sw_out", 16'(sw_in), 16'(sw_out));
      check_value("powerup override pwr_out", 16'(sw_in), 16'(pwr_out));
      run_reconfigure("powerup override", 5'd9);
      base = icap_i.log_q.size() - RECONFIG_WORDS;
      check_value("powerup override gen5", 16'({sw_in, sw_in}), 16'(icap_i.log_q[base + 9][7:0]));
      powerup = 1'b0;
   endtask

   initial
   begin
      arst_n      = 1'b0;
      design_num  = '0;
      reconfigure = 1'b0;
      powerup     = 1'b0;
      sw_in       = '0;
      busy_len    = 0;
      gen5_value  = 16'h0000;
      void'($urandom(32'h8f2c));
      gen5_value  = 16'($urandom());            // Low byte becomes the soft switch byte
      powerup_readback();
      busy_stretch();
      reconfigure_designs();
      fallback_image();
      powerup_override();
      $display("NO ERRORS");
      $finish;
   end

endmodule

// ==== verification/icap_model.sv ====
`timescale 1ns/1ps

module icap_model
(
   input  logic                     clk,
   input  logic                     arst_n,
   input  multiboot_pkg::icap_cmd_t icap_out,
   input  int                       busy_len,
   input  logic [15:0]              gen5_value,
   output logic                     busy,
   output logic [15:0]              icap_dout
);

   logic [15:0] log_q[$];                       // Words written with both strobes low
   logic        ce_n_q    = 1'b1;
   int          busy_left = 0;

   // Pin bit 0 carries word bit 7, pin bit 8 carries word bit 15
   function automatic logic [15:0] mirror_bytes(input logic [15:0] value);
      logic [15:0] result;
      for (int i = 0; i < 8; i++)
      begin
         result[i]     = value[7 - i];
         result[8 + i] = value[15 - i];
      end
      return result;
   endfunction

   assign busy      = (busy_left != 0);
   // Readback answer for GENERAL_5, valid only once busy drops
   assign icap_dout = mirror_bytes(busy ? ~gen5_value : gen5_value);

   // ------------------------------------------------------------------------
   // Port activity, sampled away from the rising edge
   // ------------------------------------------------------------------------

   always @(negedge clk)
   begin
      if (!arst_n)
      begin
         log_q.delete();
         busy_left = 0;
         ce_n_q    = 1'b1;
      end
      else
      begin
         if (busy_left != 0)
            busy_left = busy_left - 1;
         if (ce_n_q && !icap_out.ce_n && icap_out.wr_n)
            busy_left = busy_len;               // Read strobe starts the busy window
         if (!icap_out.ce_n && !icap_out.wr_n)
            log_q.push_back(mirror_bytes(icap_out.word.raw));
         ce_n_q = icap_out.ce_n;
      end
   end

endmodule

// ==== logic/icap_multiboot_top.sv ====
`timescale 1ns/1ps

module icap_multiboot_top
#(
   parameter int STARTUP_CYCLES = 15
)
(
   input  logic                        clk,
   input  logic                        arst_n,
   input  multiboot_pkg::design_num_t  design_num,
   input  logic                        reconfigure,
   input  logic                        powerup,
   input  multiboot_pkg::switch_t      sw_in,
   input  logic                        busy,
   input  logic [15:0]                 icap_dout,
   output multiboot_pkg::icap_cmd_t    icap_out,
   output multiboot_pkg::switch_t      sw_out,
   output multiboot_pkg::switch_t      pwr_out,
   output logic                        initialized
);

   logic                       ready;
   logic                       reconfigure_sync;
   logic                       dip_load;
   multiboot_pkg::icap_word_t  gen1_word;
   multiboot_pkg::icap_word_t  gen2_word;
   multiboot_pkg::icap_word_t  read_data;
   multiboot_pkg::icap_cmd_t   cmd;
   multiboot_pkg::soft_dip_t   soft_dip;

   // ------------------------------------------------------------------------
   // Input side
   // ------------------------------------------------------------------------

   request_sync #(
      .STARTUP_CYCLES   (STARTUP_CYCLES)
   ) request_sync_i (
      .clk              (clk),
      .arst_n           (arst_n),
      .reconfigure      (reconfigure),
      .ready            (ready),
      .reconfigure_sync (reconfigure_sync)
   );

   boot_address_table boot_address_table_i (
      .design_num (design_num),
      .gen1_word  (gen1_word),
      .gen2_word  (gen2_word)
   );

   // ------------------------------------------------------------------------
   // Command stream and port
   // ------------------------------------------------------------------------

   multiboot_sequencer multiboot_sequencer_i (
      .clk              (clk),
      .arst_n           (arst_n),
      .ready            (ready),
      .reconfigure_sync (reconfigure_sync),
      .busy             (busy),
      .design_num       (design_num),
      .powerup          (powerup),
      .sw_in            (sw_in),
      .soft_dip         (soft_dip),
      .gen1_word        (gen1_word),
      .gen2_word        (gen2_word),
      .cmd              (cmd),
      .dip_load         (dip_load),
      .initialized      (initialized)
   );

   icap_port icap_port_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .cmd       (cmd),
      .icap_dout (icap_dout),
      .icap_out  (icap_out),
      .read_data (read_data)
   );

   switch_select switch_select_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .dip_load  (dip_load),
      .powerup   (powerup),
      .read_data (read_data),
      .sw_in     (sw_in),
      .soft_dip  (soft_dip),
      .sw_out    (sw_out),
      .pwr_out   (pwr_out)
   );

endmodule

// ==== logic/switch_select.sv ====
`timescale 1ns/1ps

module switch_select
(
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       dip_load,
   input  logic                       powerup,
   input  multiboot_pkg::icap_word_t  read_data,
   input  multiboot_pkg::switch_t     sw_in,
   output multiboot_pkg::soft_dip_t   soft_dip,
   output multiboot_pkg::switch_t     sw_out,
   output multiboot_pkg::switch_t     pwr_out
);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         soft_dip <= '0;
      else if (dip_load)
         soft_dip <= read_data.raw[7:0];        // Low byte of GENERAL_5
   end

   // Board switches win during power-up
   assign sw_out  = powerup ? sw_in : soft_dip.sw;
   assign pwr_out = powerup ? sw_in : soft_dip.pwr;

endmodule

// ==== logic/icap_port.sv ====
`timescale 1ns/1ps

module icap_port
(
   input  logic                       clk,
   input  logic                       arst_n,
   input  multiboot_pkg::icap_cmd_t   cmd,
   input  logic [15:0]                icap_dout,
   output multiboot_pkg::icap_cmd_t   icap_out,
   output multiboot_pkg::icap_word_t  read_data
);

   // ------------------------------------------------------------------------
   // Toward the ICAP
   // ------------------------------------------------------------------------

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         icap_out <= multiboot_pkg::CMD_INACTIVE;  // Both strobes high
      end
      else
      begin
         icap_out.word.raw <= multiboot_pkg::reverse_byte_bits(cmd.word.raw);
         icap_out.ce_n     <= cmd.ce_n;
         icap_out.wr_n     <= cmd.wr_n;
      end
   end

   // ------------------------------------------------------------------------
   // From the ICAP
   // ------------------------------------------------------------------------

   // Undo the per-byte mirroring of the readback word
   assign read_data.raw = multiboot_pkg::reverse_byte_bits(icap_dout);

endmodule

// ==== logic/multiboot_sequencer.sv ====
`timescale 1ns/1ps

module multiboot_sequencer
(
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        ready,
   input  logic                        reconfigure_sync,
   input  logic                        busy,
   input  multiboot_pkg::design_num_t  design_num,
   input  logic                        powerup,
   input  multiboot_pkg::switch_t      sw_in,
   input  multiboot_pkg::soft_dip_t    soft_dip,
   input  multiboot_pkg::icap_word_t   gen1_word,
   input  multiboot_pkg::icap_word_t   gen2_word,
   output multiboot_pkg::icap_cmd_t    cmd,
   output logic                        dip_load,
   output logic                        initialized
);

   typedef enum logic [5:0]
   {
      ST_INIT,
      RD_DUMMY, RD_SYNC_HI, RD_SYNC_LO, RD_NOOP_1, RD_NOOP_2, RD_HDR_GEN5,
      RD_NOOP_3, RD_NOOP_4, RD_NOOP_5, RD_NOOP_6,
      RD_ABORT_1, RD_ABORT_2, RD_ARM, RD_LATCH, RD_ABORT_3, RD_ABORT_4,
      RD_HDR_CMD, RD_DESYNC, RD_NOOP_7, RD_NOOP_8,
      ST_IDLE,
      RB_DUMMY_1, RB_DUMMY_2, RB_SYNC_HI, RB_SYNC_LO,
      RB_HDR_GEN1, RB_GEN1, RB_HDR_GEN2, RB_GEN2, RB_HDR_GEN5, RB_GEN5,
      RB_HDR_CMD, RB_REBOOT, RB_NOOP_1, RB_NOOP_2, RB_NOOP_3, RB_NOOP_4, RB_NULL
   } state_t;

   state_t                     state;
   state_t                     state_nxt;
   multiboot_pkg::icap_word_t  gen5_word;

   function automatic multiboot_pkg::icap_cmd_t write_word(input logic [15:0] value);
      multiboot_pkg::icap_cmd_t c;
      c.word.raw = value;
      c.ce_n     = 1'b0;
      c.wr_n     = 1'b0;
      return c;
   endfunction

   // Strobe-only cycle with dummy data on the bus
   function automatic multiboot_pkg::icap_cmd_t strobe(input logic ce_n, input logic wr_n);
      multiboot_pkg::icap_cmd_t c;
      c.word.raw = multiboot_pkg::WORD_DUMMY;
      c.ce_n     = ce_n;
      c.wr_n     = wr_n;
      return c;
   endfunction

   function automatic logic [15:0] type1_hdr(input logic [1:0] opcode,
                                             input logic [5:0] reg_addr);
      multiboot_pkg::icap_word_t w;
      w.hdr.pkt_type   = multiboot_pkg::PKT_TYPE_1;
      w.hdr.opcode     = opcode;
      w.hdr.reg_addr   = reg_addr;
      w.hdr.word_count = 5'd1;
      return w.raw;
   endfunction

   // Switch byte written back for the next image
   assign gen5_word.raw = {8'h00,
                           powerup ? sw_in : soft_dip.pwr,
                           powerup ? sw_in : design_num[3:0]};

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         state <= ST_INIT;
      else
         state <= state_nxt;
   end

   // ------------------------------------------------------------------------
   // Next state
   // ------------------------------------------------------------------------

   always_comb
   begin
      state_nxt = state_t'(state + 1'b1);       // Most states just step on
      case (state)
         ST_INIT    : state_nxt = ready ? RD_DUMMY : ST_INIT;
         RD_LATCH   : state_nxt = busy ? RD_LATCH : RD_ABORT_3;
         RD_NOOP_8  : state_nxt = ST_IDLE;
         ST_IDLE    : state_nxt = reconfigure_sync ? RB_DUMMY_1 : ST_IDLE;
         RB_NULL    : state_nxt = ST_IDLE;
         default    : ;
      endcase
   end

   // ------------------------------------------------------------------------
   // Port cycle per state
   // ------------------------------------------------------------------------

   always_comb
   begin
      cmd = multiboot_pkg::CMD_INACTIVE;
      case (state)
         RD_DUMMY, RB_DUMMY_1, RB_DUMMY_2, RB_NULL:
            cmd = write_word(multiboot_pkg::WORD_DUMMY);
         RD_SYNC_HI, RB_SYNC_HI:
            cmd = write_word(multiboot_pkg::WORD_SYNC_HI);
         RD_SYNC_LO, RB_SYNC_LO:
            cmd = write_word(multiboot_pkg::WORD_SYNC_LO);
         RD_NOOP_1, RD_NOOP_2, RD_NOOP_3, RD_NOOP_4, RD_NOOP_5, RD_NOOP_6,
         RD_NOOP_7, RD_NOOP_8, RB_NOOP_1, RB_NOOP_2, RB_NOOP_3, RB_NOOP_4:
            cmd = write_word(multiboot_pkg::WORD_NOOP);
         RD_HDR_GEN5:                           // Read request for GENERAL_5
            cmd = write_word(type1_hdr(multiboot_pkg::OP_READ, multiboot_pkg::REG_GENERAL5));
         RD_ABORT_1, RD_ABORT_4:
            cmd = strobe(1'b1, 1'b0);
         RD_ABORT_2, RD_ABORT_3:
            cmd = strobe(1'b1, 1'b1);
         RD_ARM, RD_LATCH:                      // Read strobe held until busy drops
            cmd = strobe(1'b0, 1'b1);
         RD_HDR_CMD, RB_HDR_CMD:
            cmd = write_word(type1_hdr(multiboot_pkg::OP_WRITE, multiboot_pkg::REG_CMD));
         RD_DESYNC:
            cmd = write_word(multiboot_pkg::CMD_DESYNC);
         RB_HDR_GEN1:
            cmd = write_word(type1_hdr(multiboot_pkg::OP_WRITE, multiboot_pkg::REG_GENERAL1));
         RB_GEN1:
            cmd = write_word(gen1_word.raw);
         RB_HDR_GEN2:
            cmd = write_word(type1_hdr(multiboot_pkg::OP_WRITE, multiboot_pkg::REG_GENERAL2));
         RB_GEN2:
            cmd = write_word(gen2_word.raw);
         RB_HDR_GEN5:
            cmd = write_word(type1_hdr(multiboot_pkg::OP_WRITE, multiboot_pkg::REG_GENERAL5));
         RB_GEN5:
            cmd = write_word(gen5_word.raw);
         RB_REBOOT:
            cmd = write_word(multiboot_pkg::CMD_REBOOT);
         default:                               // INIT and IDLE keep the port parked
            cmd = multiboot_pkg::CMD_INACTIVE;
      endcase
   end

   assign dip_load    = (state == RD_LATCH) && !busy; // Read data valid now
   assign initialized = (state == ST_IDLE);

endmodule

// ==== logic/boot_address_table.sv ====
`timescale 1ns/1ps

module boot_address_table
(
   input  multiboot_pkg::design_num_t design_num,
   output multiboot_pkg::icap_word_t  gen1_word,
   output multiboot_pkg::icap_word_t  gen2_word
);

   // GENERAL_1 holds the low address half, GENERAL_2 the upper bits
   always_comb
   begin
      case (design_num)
         5'b10000:
         begin
            gen1_word.raw = 16'h0000;           // Base image
            gen2_word.raw = 16'h0300;
         end
         5'd0, 5'd1, 5'd2, 5'd3:
         begin
            gen1_word.raw = 16'h4000;
            gen2_word.raw = 16'h0305;
         end
         5'd4:
         begin
            gen1_word.raw = 16'h8000;
            gen2_word.raw = 16'h030A;
         end
         5'd5, 5'd6, 5'd7:
         begin
            gen1_word.raw = 16'hC000;
            gen2_word.raw = 16'h030F;
         end
         5'd8:
         begin
            gen1_word.raw = 16'h0000;
            gen2_word.raw = 16'h0315;
         end
         5'd9:
         begin
            gen1_word.raw = 16'h4000;
            gen2_word.raw = 16'h031A;
         end
         5'd10:
         begin
            gen1_word.raw = 16'h8000;
            gen2_word.raw = 16'h031F;
         end
         5'd11:
         begin
            gen1_word.raw = 16'hC000;
            gen2_word.raw = 16'h0324;
         end
         5'd12:
         begin
            gen1_word.raw = 16'h0000;
            gen2_word.raw = 16'h032A;
         end
         5'd13:
         begin
            gen1_word.raw = 16'h4000;
            gen2_word.raw = 16'h032F;
         end
         5'd15:
         begin
            gen1_word.raw = 16'hC000;
            gen2_word.raw = 16'h0339;
         end
         default:
         begin
            gen1_word.raw = 16'h8000;           // Design 14 and fallback image
            gen2_word.raw = 16'h0334;
         end
      endcase
   end

endmodule

// ==== logic/request_sync.sv ====
`timescale 1ns/1ps

module request_sync
#(
   parameter int STARTUP_CYCLES = 15
)
(
   input  logic clk,
   input  logic arst_n,
   input  logic reconfigure,
   output logic ready,
   output logic reconfigure_sync
);

   localparam int CNT_W = $clog2(STARTUP_CYCLES + 1);

   logic [CNT_W-1:0] delay_cnt;
   logic [1:0]       reconfigure_q;

   assign ready = (delay_cnt == CNT_W'(STARTUP_CYCLES)); // Saturated count

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         delay_cnt     <= '0;
         reconfigure_q <= 2'b00;
      end
      else
      begin
         if (!ready)
            delay_cnt <= delay_cnt + 1'b1;
         reconfigure_q <= {reconfigure_q[0], reconfigure}; // Two-flop synchronizer
      end
   end

   assign reconfigure_sync = reconfigure_q[1];

endmodule

// ==== logic/multiboot_pkg.sv ====
package multiboot_pkg;

   // -------------------------------------------------------------------------
   // ICAP word formats
   // -------------------------------------------------------------------------

   typedef struct packed
   {
      logic [2:0] pkt_type;                     // 001 for a type-1 packet
      logic [1:0] opcode;
      logic [5:0] reg_addr;
      logic [4:0] word_count;
   } icap_hdr_t;

   // Same 16 bits seen as payload or as packet header
   typedef union packed
   {
      logic [15:0] raw;
      icap_hdr_t   hdr;
   } icap_word_t;

   // One port cycle, strobes active low like the primitive
   typedef struct packed
   {
      icap_word_t word;
      logic       ce_n;
      logic       wr_n;
   } icap_cmd_t;

   // -------------------------------------------------------------------------
   // Packet fields and fixed words
   // -------------------------------------------------------------------------

   localparam logic [2:0] PKT_TYPE_1   = 3'b001;

   localparam logic [1:0] OP_NOOP      = 2'b00;
   localparam logic [1:0] OP_READ      = 2'b01;
   localparam logic [1:0] OP_WRITE     = 2'b10;

   localparam logic [5:0] REG_CMD      = 6'h05;
   localparam logic [5:0] REG_GENERAL1 = 6'h13;
   localparam logic [5:0] REG_GENERAL2 = 6'h14;
   localparam logic [5:0] REG_GENERAL5 = 6'h17;

   localparam logic [15:0] WORD_DUMMY   = 16'hFFFF;
   localparam logic [15:0] WORD_SYNC_HI = 16'hAA99;
   localparam logic [15:0] WORD_SYNC_LO = 16'h5566;
   localparam logic [15:0] WORD_NOOP    = 16'h2000; // Type-1 header with OP_NOOP
   localparam logic [15:0] CMD_REBOOT   = 16'h000E;
   localparam logic [15:0] CMD_DESYNC   = 16'h000D;

   // Port parked with both strobes high
   localparam icap_cmd_t CMD_INACTIVE = {WORD_DUMMY, 1'b1, 1'b1};

   // -------------------------------------------------------------------------
   // Board side types
   // -------------------------------------------------------------------------

   typedef logic [4:0] design_num_t;
   typedef logic [3:0] switch_t;

   typedef struct packed
   {
      switch_t pwr;                             // High nibble
      switch_t sw;                              // Low nibble
   } soft_dip_t;

   // ICAP shifts D0 first, so each byte is mirrored on the pins
   function automatic logic [15:0] reverse_byte_bits(input logic [15:0] value);
      logic [15:0] result;
      for (int i = 0; i < 8; i++)
      begin
         result[i]     = value[7 - i];
         result[8 + i] = value[15 - i];
      end
      return result;
   endfunction

endpackage
